/* Makefile */
VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tlb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_tb import tlb_pkg::*; ();

    localparam logic [2:0] KIND_WRITE = 3'd0;
    localparam logic [2:0] KIND_READ  = 3'd1;
    localparam logic [2:0] KIND_FETCH = 3'd2;
    localparam logic [2:0] KIND_LOAD  = 3'd3;
    localparam logic [2:0] KIND_STORE = 3'd4;
    localparam logic [2:0] KIND_PROBE = 3'd5;

    // bit order follows tlb_exc_t
    localparam tlb_exc_t EXC_NONE      = 5'b00000;
    localparam tlb_exc_t EXC_I_REFILL  = 5'b10000;
    localparam tlb_exc_t EXC_I_INVALID = 5'b01000;
    localparam tlb_exc_t EXC_D_REFILL  = 5'b00100;
    localparam tlb_exc_t EXC_D_INVALID = 5'b00010;
    localparam tlb_exc_t EXC_D_MODIFY  = 5'b00001;

    // exp0..exp2 are the read words, or tag and uncached, or the probe index
    typedef struct packed {
        logic [2:0] kind;
        logic [7:0] idx;
        vaddr_t     hi;
        vaddr_t     lo0;
        vaddr_t     lo1;
        vaddr_t     addr;
        cattr_t     k0;
        vaddr_t     exp0;
        vaddr_t     exp1;
        vaddr_t     exp2;
        tlb_exc_t   exp_exc;
    } row_t;

    logic       clk;
    logic       resetn;
    cattr_t     i_k0;
    logic       i_we;
    logic [7:0] i_w_index;
    vaddr_t     i_w_hi;
    vaddr_t     i_w_lo0;
    vaddr_t     i_w_lo1;
    logic [7:0] i_r_index;
    logic       i_inst_en;
    vaddr_t     i_inst_vaddr;
    logic       i_data_ren;
    logic       i_data_wen;
    vaddr_t     i_data_vaddr;
    logic       i_op_tlbp;
    logic       o_inst_uncached;
    ptag_t      o_inst_tag;
    logic       o_data_uncached;
    ptag_t      o_data_tag;
    vaddr_t     o_p_index;
    vaddr_t     o_r_hi;
    vaddr_t     o_r_lo0;
    vaddr_t     o_r_lo1;
    tlb_exc_t   o_exc;

    int   seed;
    row_t rows[$];

    tlb_top #(.NUM_ENTRIES(16)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
    end

    // EntryHi is {vpn2, 5'b0, asid}, EntryLo is {6'b0, pfn, c, d, v, g}
    function automatic vaddr_t hi_word(input vpn2_t vpn2, input asid_t asid);
        return {vpn2, 5'b0, asid};
    endfunction

    function automatic vaddr_t lo_word(input pfn_t pfn, input cattr_t c, input logic [2:0] dvg);
        return {6'b0, pfn, c, dvg};
    endfunction

    task automatic add_row(input logic [2:0] kind, input logic [7:0] idx, input vaddr_t hi,
                           input vaddr_t lo0, input vaddr_t lo1, input vaddr_t addr,
                           input cattr_t k0, input vaddr_t exp0, input vaddr_t exp1,
                           input vaddr_t exp2, input tlb_exc_t exp_exc);
        row_t r;
        r = '{kind, idx, hi, lo0, lo1, addr, k0, exp0, exp1, exp2, exp_exc};
        rows.push_back(r);
    endtask

    // junk in EntryHi bits 12..8 must read back as zero
    // one global bit per entry, set only when both G bits are
    task automatic add_write(input logic [7:0] idx, input vaddr_t hi, input vaddr_t lo0,
                             input vaddr_t lo1);
        logic g;
        g = lo0[0] & lo1[0];
        add_row(KIND_WRITE, idx, hi | 32'h0000_1f00, lo0, lo1, '0, '0, hi,
                {lo0[31:1], g}, {lo1[31:1], g}, EXC_NONE);
    endtask

    task automatic add_lookup(input logic [2:0] kind, input asid_t asid, input vaddr_t addr,
                              input cattr_t k0, input ptag_t tag, input logic uncached,
                              input tlb_exc_t exp_exc);
        add_row(kind, 8'd0, hi_word('0, asid), '0, '0, addr, k0, 32'(tag), 32'(uncached),
                '0, exp_exc);
    endtask

    task automatic add_probe(input vaddr_t hi, input vaddr_t exp_index);
        add_row(KIND_PROBE, 8'd0, hi, '0, '0, '0, '0, exp_index, '0, '0, EXC_NONE);
    endtask

    task automatic build_table();
        vpn2_t  vpn2;
        asid_t  asid;
        pfn_t   pfn0;
        pfn_t   pfn1;
        cattr_t c;
        // after reset every entry is vpn2 0, asid 0, invalid
        for (int i = 0; i < 16; i++) begin
            add_row(KIND_READ, 8'(i), '0, '0, '0, '0, '0, '0, '0, '0, EXC_NONE);
        end
        add_lookup(KIND_LOAD, 8'd0, 32'h0000_0000, 3'd0, 20'h0, 1'b1, EXC_D_INVALID);
        add_lookup(KIND_FETCH, 8'd0, 32'h0000_0000, 3'd0, 20'h0, 1'b1, EXC_I_INVALID);
        add_write(8'd1, hi_word(19'h200, 8'd5), lo_word(20'h12345, 3'd3, 3'b110),
                  lo_word(20'h0abcd, 3'd2, 3'b010));
        add_row(KIND_READ, 8'd1, '0, '0, '0, '0, '0, hi_word(19'h200, 8'd5),
                lo_word(20'h12345, 3'd3, 3'b110), lo_word(20'h0abcd, 3'd2, 3'b010), EXC_NONE);
        add_lookup(KIND_FETCH, 8'd5, 32'h0040_0000, 3'd0, 20'h12345, 1'b0, EXC_NONE);
        add_lookup(KIND_FETCH, 8'd5, 32'h0040_1000, 3'd0, 20'h0abcd, 1'b1, EXC_NONE);
        add_lookup(KIND_FETCH, 8'd6, 32'h0040_0000, 3'd0, 20'h0, 1'b1, EXC_I_REFILL);
        add_lookup(KIND_FETCH, 8'd5, 32'h1234_0000, 3'd0, 20'h0, 1'b1, EXC_I_REFILL);
        // both G bits set, any asid hits
        add_write(8'd2, hi_word(19'h400, 8'd7), lo_word(20'h22222, 3'd3, 3'b111),
                  lo_word(20'h33333, 3'd3, 3'b101));
        add_lookup(KIND_FETCH, 8'd9, 32'h0080_0000, 3'd0, 20'h22222, 1'b0, EXC_NONE);
        add_lookup(KIND_FETCH, 8'd9, 32'h0080_1000, 3'd0, 20'h33333, 1'b0, EXC_I_INVALID);
        // only one G bit, so still asid bound
        add_write(8'd3, hi_word(19'h600, 8'd7), lo_word(20'h03030, 3'd3, 3'b111),
                  lo_word(20'h03131, 3'd3, 3'b110));
        add_lookup(KIND_FETCH, 8'd9, 32'h00c0_0000, 3'd0, 20'h0, 1'b1, EXC_I_REFILL);
        add_lookup(KIND_FETCH, 8'd7, 32'h00c0_0000, 3'd0, 20'h03030, 1'b0, EXC_NONE);
        // two matches, lowest index wins
        add_write(8'd6, hi_word(19'h800, 8'd5), lo_word(20'h66666, 3'd3, 3'b110),
                  lo_word(20'h66667, 3'd3, 3'b110));
        add_lookup(KIND_FETCH, 8'd5, 32'h0100_0000, 3'd0, 20'h66666, 1'b0, EXC_NONE);
        add_write(8'd4, hi_word(19'h800, 8'd5), lo_word(20'h44444, 3'd3, 3'b110),
                  lo_word(20'h44445, 3'd3, 3'b110));
        add_lookup(KIND_FETCH, 8'd5, 32'h0100_0000, 3'd0, 20'h44444, 1'b0, EXC_NONE);
        // even page clean, odd page dirty and uncached
        add_write(8'd5, hi_word(19'h8000, 8'd5), lo_word(20'h55555, 3'd3, 3'b010),
                  lo_word(20'h5aaaa, 3'd2, 3'b110));
        add_lookup(KIND_STORE, 8'd5, 32'h1000_0000, 3'd0, 20'h55555, 1'b0, EXC_D_MODIFY);
        add_lookup(KIND_LOAD, 8'd5, 32'h1000_0000, 3'd0, 20'h55555, 1'b0, EXC_NONE);
        add_lookup(KIND_STORE, 8'd5, 32'h1000_1000, 3'd0, 20'h5aaaa, 1'b1, EXC_NONE);
        add_lookup(KIND_LOAD, 8'd5, 32'hc000_0000, 3'd0, 20'h0, 1'b1, EXC_D_REFILL);
        // unmapped segments never raise exceptions
        add_lookup(KIND_LOAD, 8'd5, 32'h8123_4567, 3'd3, 20'h01234, 1'b0, EXC_NONE);
        add_lookup(KIND_LOAD, 8'd5, 32'h8123_4567, 3'd2, 20'h01234, 1'b1, EXC_NONE);
        add_lookup(KIND_LOAD, 8'd5, 32'ha123_4567, 3'd3, 20'h01234, 1'b1, EXC_NONE);
        add_lookup(KIND_FETCH, 8'd5, 32'h9fc0_0000, 3'd3, 20'h1fc00, 1'b0, EXC_NONE);
        add_lookup(KIND_FETCH, 8'd5, 32'hbfc0_0000, 3'd3, 20'h1fc00, 1'b1, EXC_NONE);
        add_lookup(KIND_STORE, 8'd5, 32'h8000_0000, 3'd3, 20'h00000, 1'b0, EXC_NONE);
        add_probe(hi_word(19'h200, 8'd5), 32'd1);
        add_probe(hi_word(19'h800, 8'd5), 32'd4);
        add_probe(hi_word(19'h400, 8'd99), 32'd2);
        add_probe(hi_word(19'h7777, 8'd5), 32'h8000_0000);
        // random vpn2 in 0x6000_0000..0x7fff_ffff, kept apart by the loop count
        for (int i = 0; i < 4; i++) begin
            vpn2 = {3'b011, 2'(i), 14'($random(seed))};
            asid = 8'($random(seed));
            pfn0 = 20'($random(seed));
            pfn1 = 20'($random(seed));
            c    = ($random(seed) & 1) ? CACHE_CACHEABLE : 3'd2;
            add_write(8'(8 + i), hi_word(vpn2, asid), lo_word(pfn0, c, 3'b110),
                      lo_word(pfn1, 3'd2, 3'b110));
            add_lookup(KIND_FETCH, asid, {vpn2, 13'h0000}, 3'd0, pfn0,
                       c != CACHE_CACHEABLE, EXC_NONE);
            add_lookup(KIND_LOAD, asid, {vpn2, 13'h1000}, 3'd0, pfn1, 1'b1, EXC_NONE);
        end
    endtask

    task automatic apply_rows(output int n_pass, output int n_fail);
        row_t   r;
        vaddr_t got0;
        vaddr_t got1;
        vaddr_t got2;
        n_pass = 0;
        n_fail = 0;
        foreach (rows[n]) begin
            r = rows[n];
            @(posedge clk);
            #1;
            i_we         = (r.kind == KIND_WRITE);
            i_w_index    = r.idx;
            i_r_index    = r.idx;
            i_w_hi       = r.hi;
            i_w_lo0      = r.lo0;
            i_w_lo1      = r.lo1;
            i_k0         = r.k0;
            i_inst_en    = (r.kind == KIND_FETCH);
            i_inst_vaddr = r.addr;
            i_data_ren   = (r.kind == KIND_LOAD);
            i_data_wen   = (r.kind == KIND_STORE);
            i_data_vaddr = r.addr;
            i_op_tlbp    = (r.kind == KIND_PROBE);
            // sample just before the next edge
            #8;
            case (r.kind)
                KIND_WRITE, KIND_READ: begin
                    got0 = o_r_hi;
                    got1 = o_r_lo0;
                    got2 = o_r_lo1;
                end
                KIND_FETCH: begin
                    got0 = 32'(o_inst_tag);
                    got1 = 32'(o_inst_uncached);
                    got2 = '0;
                end
                KIND_PROBE: begin
                    got0 = o_p_index;
                    got1 = '0;
                    got2 = '0;
                end
                default: begin
                    got0 = 32'(o_data_tag);
                    got1 = 32'(o_data_uncached);
                    got2 = '0;
                end
            endcase
            if (got0 !== r.exp0 || got1 !== r.exp1 || got2 !== r.exp2
                    || o_exc !== r.exp_exc) begin
                n_fail++;
                $display("FAILED t=%0t row %0d kind %0d: got %h %h %h exc %b, want %h %h %h exc %b",
                         $time, n, r.kind, got0, got1, got2, o_exc,
                         r.exp0, r.exp1, r.exp2, r.exp_exc);
            end else begin
                n_pass++;
                $display("row %0d kind %0d ok", n, r.kind);
            end
        end
    endtask

    initial begin
        int n_pass;
        int n_fail;
        int waited;
        seed         = 32'hbbf0_295b;
        i_k0         = '0;
        i_we         = 1'b0;
        i_w_index    = '0;
        i_w_hi       = '0;
        i_w_lo0      = '0;
        i_w_lo1      = '0;
        i_r_index    = '0;
        i_inst_en    = 1'b0;
        i_inst_vaddr = '0;
        i_data_ren   = 1'b0;
        i_data_wen   = 1'b0;
        i_data_vaddr = '0;
        i_op_tlbp    = 1'b0;
        build_table();
        waited = 0;
        while (resetn !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (resetn !== 1'b1) begin
            $display("reset was not released within 20 cycles, timed out");
            $display("** FAIL **");
        end else begin
            apply_rows(n_pass, n_fail);
            $display("rows run %0d, passed %0d, failed %0d", rows.size(), n_pass, n_fail);
            if (n_fail == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/mmu_translate.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_translate import tlb_pkg::*; (
    input  wire cattr_t      i_k0,
    input  wire logic        i_inst_en,
    input  wire vaddr_t      i_inst_vaddr,
    input  wire tlb_result_t i_inst_result,
    input  wire logic        i_data_ren,
    input  wire logic        i_data_wen,
    input  wire vaddr_t      i_data_vaddr,
    input  wire tlb_result_t i_data_result,
    output ptag_t            o_inst_tag,
    output logic             o_inst_uncached,
    output ptag_t            o_data_tag,
    output logic             o_data_uncached,
    output tlb_exc_t         o_exc
);

    logic inst_mapped;
    logic data_mapped;
    logic data_access;

    // kseg0 and kseg1 bypass the TLB
    function automatic logic is_mapped(input vaddr_t va);
        logic [2:0] seg;
        seg = va[31 -: 3];
        return !((seg == SEG_KSEG0) || (seg == SEG_KSEG1));
    endfunction

    function automatic ptag_t seg_tag(input vaddr_t va, input tlb_result_t res);
        if (is_mapped(va)) begin
            return res.pfn;
        end
        return ptag_t'({3'b000, va[28:ODD_PAGE_BIT]});
    endfunction

    function automatic logic seg_uncached(input vaddr_t va, input cattr_t k0,
                                          input cattr_t c);
        logic [2:0] seg;
        seg = va[31 -: 3];
        if (seg == SEG_KSEG1) begin
            return 1'b1;
        end
        if (seg == SEG_KSEG0) begin
            return k0 != CACHE_CACHEABLE;
        end
        return c != CACHE_CACHEABLE;
    endfunction

    assign inst_mapped = is_mapped(i_inst_vaddr);
    assign data_mapped = is_mapped(i_data_vaddr);
    assign data_access = i_data_ren | i_data_wen;

    assign o_inst_tag      = seg_tag(i_inst_vaddr, i_inst_result);
    assign o_inst_uncached = seg_uncached(i_inst_vaddr, i_k0, i_inst_result.c);
    assign o_data_tag      = seg_tag(i_data_vaddr, i_data_result);
    assign o_data_uncached = seg_uncached(i_data_vaddr, i_k0, i_data_result.c);

    always_comb begin
        o_exc.i_refill  = inst_mapped & i_inst_en & ~i_inst_result.found;
        o_exc.i_invalid = inst_mapped & i_inst_en & i_inst_result.found & ~i_inst_result.v;
        o_exc.d_refill  = data_mapped & data_access & ~i_data_result.found;
        o_exc.d_invalid = data_mapped & data_access & i_data_result.found
                        & ~i_data_result.v;
        // store to a clean page
        o_exc.d_modify  = data_mapped & i_data_wen & i_data_result.found
                        & i_data_result.v & ~i_data_result.d;
    end

endmodule

`default_nettype wire

/* source/tlb_cp0_format.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_cp0_format import tlb_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  wire vaddr_t      i_w_hi,
    input  wire vaddr_t      i_w_lo0,
    input  wire vaddr_t      i_w_lo1,
    input  wire vaddr_t      i_inst_vaddr,
    input  wire vaddr_t      i_data_vaddr,
    input  wire logic        i_op_tlbp,
    input  wire tlb_entry_t  i_r_entry,
    input  wire tlb_result_t i_data_result,
    output tlb_entry_t       o_w_entry,
    output tlb_key_t         o_inst_key,
    output tlb_key_t         o_data_key,
    output vaddr_t           o_r_hi,
    output vaddr_t           o_r_lo0,
    output vaddr_t           o_r_lo1,
    output vaddr_t           o_p_index
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    function automatic tlb_page_t unpack_lo(input vaddr_t lo);
        tlb_page_t page;
        page.pfn = lo[PFN_LSB +: $bits(pfn_t)];
        page.c   = lo[C_LSB +: $bits(cattr_t)];
        page.d   = lo[D_BIT];
        page.v   = lo[V_BIT];
        return page;
    endfunction

    function automatic vaddr_t pack_lo(input tlb_page_t page, input logic g);
        vaddr_t lo;
        lo = '0;
        lo[PFN_LSB +: $bits(pfn_t)] = page.pfn;
        lo[C_LSB +: $bits(cattr_t)] = page.c;
        lo[D_BIT] = page.d;
        lo[V_BIT] = page.v;
        lo[G_BIT] = g;
        return lo;
    endfunction

    always_comb begin
        o_w_entry.vpn2  = i_w_hi[VPN2_LSB +: $bits(vpn2_t)];
        o_w_entry.asid  = i_w_hi[$bits(asid_t)-1:0];
        // global only if both halves say so
        o_w_entry.g     = i_w_lo0[G_BIT] & i_w_lo1[G_BIT];
        o_w_entry.page0 = unpack_lo(i_w_lo0);
        o_w_entry.page1 = unpack_lo(i_w_lo1);
    end

    // asid always comes from EntryHi
    always_comb begin
        o_inst_key.vpn2 = i_inst_vaddr[VPN2_LSB +: $bits(vpn2_t)];
        o_inst_key.odd  = i_inst_vaddr[ODD_PAGE_BIT];
        o_inst_key.asid = i_w_hi[$bits(asid_t)-1:0];

        o_data_key.asid = i_w_hi[$bits(asid_t)-1:0];
        if (i_op_tlbp) begin
            o_data_key.vpn2 = i_w_hi[VPN2_LSB +: $bits(vpn2_t)];
            o_data_key.odd  = i_w_hi[ODD_PAGE_BIT];
        end else begin
            o_data_key.vpn2 = i_data_vaddr[VPN2_LSB +: $bits(vpn2_t)];
            o_data_key.odd  = i_data_vaddr[ODD_PAGE_BIT];
        end
    end

    always_comb begin
        o_r_hi = '0;
        o_r_hi[VPN2_LSB +: $bits(vpn2_t)] = i_r_entry.vpn2;
        o_r_hi[$bits(asid_t)-1:0]         = i_r_entry.asid;
        o_r_lo0 = pack_lo(i_r_entry.page0, i_r_entry.g);
        o_r_lo1 = pack_lo(i_r_entry.page1, i_r_entry.g);
    end

    // probe result, miss flag alone on no hit
    always_comb begin
        o_p_index = '0;
        if (i_data_result.found) begin
            o_p_index[IDX_W-1:0] = i_data_result.index[IDX_W-1:0];
        end else begin
            o_p_index[PROBE_MISS_BIT] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/tlb_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array import tlb_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  wire logic                         clk,
    input  wire logic                         resetn,
    input  wire logic                         i_we,
    input  wire logic [7:0]                   i_w_index,
    input  wire tlb_entry_t                   i_w_entry,
    input  wire logic [7:0]                   i_r_index,
    output tlb_entry_t [NUM_ENTRIES-1:0]      o_entries,
    output tlb_entry_t                        o_r_entry
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    tlb_entry_t [NUM_ENTRIES-1:0] entries_q;
    logic [IDX_W-1:0]             w_idx;
    logic [IDX_W-1:0]             r_idx;
    logic                         w_bypass;

    assign w_idx = i_w_index[IDX_W-1:0];
    assign r_idx = i_r_index[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            entries_q <= '0;
        end else if (i_we) begin
            entries_q[w_idx] <= i_w_entry;
        end
    end

    assign o_entries = entries_q;

    // same-index write shows up on the read port in the write cycle
    assign w_bypass = i_we && (i_w_index == i_r_index);

    always_comb begin
        if (w_bypass) begin
            o_r_entry = i_w_entry;
        end else if (i_r_index < NUM_ENTRIES) begin
            o_r_entry = entries_q[r_idx];
        end else begin
            o_r_entry = '0;
        end
    end

    a_w_index_range: assert property (@(posedge clk) disable iff (!resetn)
        i_we |-> (i_w_index < NUM_ENTRIES));

endmodule

`default_nettype wire

/* source/tlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup import tlb_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  wire tlb_entry_t [NUM_ENTRIES-1:0] i_entries,
    input  wire tlb_key_t                     i_key,
    output tlb_result_t                       o_result
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    logic [NUM_ENTRIES-1:0] hit;
    logic [IDX_W-1:0]       sel_idx;
    tlb_entry_t             sel_entry;
    tlb_page_t              sel_page;

    // vpn2 must match, asid only for non-global entries
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            hit[i] = (i_entries[i].vpn2 == i_key.vpn2)
                  && (i_entries[i].g || (i_entries[i].asid == i_key.asid));
        end
    end

    // lowest index wins, so scan downward
    always_comb begin
        sel_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_entry = i_entries[sel_idx];
    assign sel_page  = i_key.odd ? sel_entry.page1 : sel_entry.page0;

    always_comb begin
        o_result = '0;
        if (|hit) begin
            o_result.found = 1'b1;
            o_result.pfn   = sel_page.pfn;
            o_result.c     = sel_page.c;
            o_result.d     = sel_page.d;
            o_result.v     = sel_page.v;
            o_result.index = 8'(sel_idx);
        end
    end

endmodule

`default_nettype wire

/* source/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] vaddr_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [19:0] ptag_t;

    localparam cattr_t CACHE_CACHEABLE = 3'd3;

    // top three address bits of the unmapped segments
    localparam logic [2:0] SEG_KSEG0 = 3'd4;
    localparam logic [2:0] SEG_KSEG1 = 3'd5;

    // EntryHi / EntryLo / address field positions
    localparam int VPN2_LSB     = 13;
    localparam int ODD_PAGE_BIT = 12;
    localparam int PFN_LSB      = 6;
    localparam int C_LSB        = 3;
    localparam int D_BIT        = 2;
    localparam int V_BIT        = 1;
    localparam int G_BIT        = 0;

    localparam int PROBE_MISS_BIT = 31;

    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;
        logic   v;
    } tlb_page_t;

    // one page pair
    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        vpn2_t vpn2;
        logic  odd;
        asid_t asid;
    } tlb_key_t;

    // index is wide enough for 256 entries, only the low bits are live
    typedef struct packed {
        logic       found;
        pfn_t       pfn;
        cattr_t     c;
        logic       d;
        logic       v;
        logic [7:0] index;
    } tlb_result_t;

    typedef struct packed {
        logic i_refill;
        logic i_invalid;
        logic d_refill;
        logic d_invalid;
        logic d_modify;
    } tlb_exc_t;

endpackage

`default_nettype wire

/* source/tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_top import tlb_pkg::*; #(
    parameter int NUM_ENTRIES = 16
) (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire cattr_t     i_k0,
    input  wire logic       i_we,
    input  wire logic [7:0] i_w_index,
    input  wire vaddr_t     i_w_hi,
    input  wire vaddr_t     i_w_lo0,
    input  wire vaddr_t     i_w_lo1,
    input  wire logic [7:0] i_r_index,
    input  wire logic       i_inst_en,
    input  wire vaddr_t     i_inst_vaddr,
    input  wire logic       i_data_ren,
    input  wire logic       i_data_wen,
    input  wire vaddr_t     i_data_vaddr,
    input  wire logic       i_op_tlbp,
    output logic            o_inst_uncached,
    output ptag_t           o_inst_tag,
    output logic            o_data_uncached,
    output ptag_t           o_data_tag,
    output vaddr_t          o_p_index,
    output vaddr_t          o_r_hi,
    output vaddr_t          o_r_lo0,
    output vaddr_t          o_r_lo1,
    output tlb_exc_t        o_exc
);

    tlb_entry_t                   w_entry;
    tlb_entry_t                   r_entry;
    tlb_entry_t [NUM_ENTRIES-1:0] entries;
    tlb_key_t                     inst_key;
    tlb_key_t                     data_key;
    tlb_result_t                  inst_result;
    tlb_result_t                  data_result;

    tlb_cp0_format #(.NUM_ENTRIES(NUM_ENTRIES)) u_cp0_format (
        .i_w_hi        (i_w_hi),
        .i_w_lo0       (i_w_lo0),
        .i_w_lo1       (i_w_lo1),
        .i_inst_vaddr  (i_inst_vaddr),
        .i_data_vaddr  (i_data_vaddr),
        .i_op_tlbp     (i_op_tlbp),
        .i_r_entry     (r_entry),
        .i_data_result (data_result),
        .o_w_entry     (w_entry),
        .o_inst_key    (inst_key),
        .o_data_key    (data_key),
        .o_r_hi        (o_r_hi),
        .o_r_lo0       (o_r_lo0),
        .o_r_lo1       (o_r_lo1),
        .o_p_index     (o_p_index)
    );

    tlb_entry_array #(.NUM_ENTRIES(NUM_ENTRIES)) u_entry_array (
        .clk       (clk),
        .resetn    (resetn),
        .i_we      (i_we),
        .i_w_index (i_w_index),
        .i_w_entry (w_entry),
        .i_r_index (i_r_index),
        .o_entries (entries),
        .o_r_entry (r_entry)
    );

    tlb_lookup #(.NUM_ENTRIES(NUM_ENTRIES)) u_inst_lookup (
        .i_entries (entries),
        .i_key     (inst_key),
        .o_result  (inst_result)
    );

    // also serves TLBP
    tlb_lookup #(.NUM_ENTRIES(NUM_ENTRIES)) u_data_lookup (
        .i_entries (entries),
        .i_key     (data_key),
        .o_result  (data_result)
    );

    mmu_translate u_mmu_translate (
        .i_k0            (i_k0),
        .i_inst_en       (i_inst_en),
        .i_inst_vaddr    (i_inst_vaddr),
        .i_inst_result   (inst_result),
        .i_data_ren      (i_data_ren),
        .i_data_wen      (i_data_wen),
        .i_data_vaddr    (i_data_vaddr),
        .i_data_result   (data_result),
        .o_inst_tag      (o_inst_tag),
        .o_inst_uncached (o_inst_uncached),
        .o_data_tag      (o_data_tag),
        .o_data_uncached (o_data_uncached),
        .o_exc           (o_exc)
    );

endmodule

`default_nettype wire

/* verilog.f */
source/tlb_pkg.sv
source/tlb_cp0_format.sv
source/tlb_entry_array.sv
source/tlb_lookup.sv
source/mmu_translate.sv
source/tlb_top.sv
bench/tlb_tb.sv
